// ==== compile.f ====
+incdir+.
rrvPkg.sv
rrvIfs.sv
rrvDecode.sv
rrvHazard.sv
rrvCtrlPipe.sv
rrvCtrl.sv
tbRrvCtrl.sv

// ==== rrvCtrl.sv ====
// RV32I five-stage control unit top, decode, hazard and pipe blocks on plain ports
`timescale 1ns/1ps

module rrvCtrl
    import rrvPkg::*;
(
    input  logic        Clock,
    input  logic        arstN,
    // Fetch side
    input  tWord        PreInstructionQ101H,
    input  tWord        PcQ101H,
    // Datapath feedback
    input  logic        BranchCondMetQ102H,
    input  logic        DMemReady,
    // Back-pressure
    output logic        ReadyQ100H,
    output logic        ReadyQ101H,
    output logic        SelNextPcAluOutQ102H,
    // Q101 register file read and immediate
    output tRegIdx      RegSrc1Q101H,
    output tRegIdx      RegSrc2Q101H,
    output tWord        ImmediateQ101H,
    // Execute
    output tAluOp       AluOpQ102H,
    output tBranchType  BranchOpQ102H,
    output logic        LuiQ102H,
    output logic        SelAluPcQ102H,
    output logic        SelAluImmQ102H,
    // Data memory
    output logic        DMemWrEnQ103H,
    output logic        DMemRdEnQ103H,
    output tByteEn      DMemByteEnQ103H,
    // Write-back
    output tRegIdx      RegDstQ105H,
    output logic        RegWrEnQ105H,
    output logic        SignExtQ105H,
    output tSelWb       SelWrBackQ105H,
    output logic        ValidInstQ105H
);

    logic insertNop;
    logic readyQ101;

    ctrlWordIf ctrlIf ();
    hazardFbIf fbIf ();

    rrvDecode uDecode (
        .preInstruction (PreInstructionQ101H),
        .insertNop      (insertNop),
        .immediate      (ImmediateQ101H),
        .ctrl           (ctrlIf.dec)
    );

    rrvHazard uHazard (
        .Clock           (Clock),
        .arstN           (arstN),
        .DMemReady       (DMemReady),
        .preInstruction  (PreInstructionQ101H),
        .branchCondMet   (BranchCondMetQ102H),
        .fb              (fbIf.haz),
        .insertNop       (insertNop),
        .readyQ101       (readyQ101),
        .readyQ100       (ReadyQ100H),
        .selNextPcAluOut (SelNextPcAluOutQ102H)
    );

    rrvCtrlPipe uPipe (
        .Clock           (Clock),
        .arstN           (arstN),
        .DMemReady       (DMemReady),
        .readyQ101       (readyQ101),
        .ctrl            (ctrlIf.pipe),
        .fb              (fbIf.pipe),
        .AluOpQ102H      (AluOpQ102H),
        .BranchOpQ102H   (BranchOpQ102H),
        .LuiQ102H        (LuiQ102H),
        .SelAluPcQ102H   (SelAluPcQ102H),
        .SelAluImmQ102H  (SelAluImmQ102H),
        .DMemWrEnQ103H   (DMemWrEnQ103H),
        .DMemRdEnQ103H   (DMemRdEnQ103H),
        .DMemByteEnQ103H (DMemByteEnQ103H),
        .RegDstQ105H     (RegDstQ105H),
        .RegWrEnQ105H    (RegWrEnQ105H),
        .SignExtQ105H    (SignExtQ105H),
        .SelWrBackQ105H  (SelWrBackQ105H),
        .ValidInstQ105H  (ValidInstQ105H)
    );

    assign ReadyQ101H   = readyQ101;
    // Source indices of the decoded word, zero on a bubble
    assign RegSrc1Q101H = ctrlIf.regSrc1;
    assign RegSrc2Q101H = ctrlIf.regSrc2;

endmodule

// ==== rrvCtrlPipe.sv ====
// Control word and valid registers from Q102 to Q105 under the global freeze
`timescale 1ns/1ps
`include "rrv_defines.svh"

module rrvCtrlPipe
    import rrvPkg::*;
(
    input  logic        Clock,
    input  logic        arstN,
    input  logic        DMemReady,
    input  logic        readyQ101,
    ctrlWordIf.pipe     ctrl,
    hazardFbIf.pipe     fb,
    output tAluOp       AluOpQ102H,
    output tBranchType  BranchOpQ102H,
    output logic        LuiQ102H,
    output logic        SelAluPcQ102H,
    output logic        SelAluImmQ102H,
    output logic        DMemWrEnQ103H,
    output logic        DMemRdEnQ103H,
    output tByteEn      DMemByteEnQ103H,
    output tRegIdx      RegDstQ105H,
    output logic        RegWrEnQ105H,
    output logic        SignExtQ105H,
    output tSelWb       SelWrBackQ105H,
    output logic        ValidInstQ105H
);

    logic [`RRV_PIPE_DEPTH:2] preValid;    // Stage valid before freeze
    logic   validQ101, validQ102, validQ103;
    tRegIdx regDstQ102, regDstQ103, regDstQ104;
    tOpcode opcodeQ102, opcodeQ103;
    logic   selNextPcJQ102, selNextPcBQ102;
    logic   regWrEnQ102, regWrEnQ103, regWrEnQ104, regWrEnQ105;
    logic   dMemWrEnQ102, dMemRdEnQ102;
    tByteEn dMemByteEnQ102;
    logic   signExtQ102, signExtQ103, signExtQ104;
    tSelWb  selWbQ102, selWbQ103, selWbQ104;

    // ------------------------------------------------------------------------
    // Valid chain
    // ------------------------------------------------------------------------
    assign validQ101 = ctrl.preValid && readyQ101;

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            preValid <= '0;
        end else if (DMemReady) begin
            preValid <= {preValid[`RRV_PIPE_DEPTH-1:2], validQ101};
        end
    end

    assign validQ102      = preValid[2] && DMemReady;
    assign validQ103      = preValid[3] && DMemReady;
    assign ValidInstQ105H = preValid[`RRV_PIPE_DEPTH] && DMemReady;

    // ------------------------------------------------------------------------
    // Control registers, all frozen together
    // ------------------------------------------------------------------------
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            regDstQ102 <= '0; opcodeQ102 <= tOpcode'(7'd0);
            AluOpQ102H <= ADD; BranchOpQ102H <= BEQ;
            LuiQ102H <= 1'b0; SelAluPcQ102H <= 1'b0; SelAluImmQ102H <= 1'b0;
            selNextPcJQ102 <= 1'b0; selNextPcBQ102 <= 1'b0;
            regWrEnQ102 <= 1'b0; dMemWrEnQ102 <= 1'b0; dMemRdEnQ102 <= 1'b0;
            dMemByteEnQ102 <= '0; signExtQ102 <= 1'b0; selWbQ102 <= WB_ALU;
        end else if (DMemReady) begin  // Q101 -> Q102
            regDstQ102 <= ctrl.regDst; opcodeQ102 <= ctrl.opcode;
            AluOpQ102H <= ctrl.aluOp; BranchOpQ102H <= ctrl.branchOp;
            LuiQ102H <= ctrl.lui; SelAluPcQ102H <= ctrl.selAluPc;
            SelAluImmQ102H <= ctrl.selAluImm;
            selNextPcJQ102 <= ctrl.selNextPcJ; selNextPcBQ102 <= ctrl.selNextPcB;
            regWrEnQ102 <= ctrl.regWrEn; dMemWrEnQ102 <= ctrl.dMemWrEn;
            dMemRdEnQ102 <= ctrl.dMemRdEn; dMemByteEnQ102 <= ctrl.dMemByteEn;
            signExtQ102 <= ctrl.signExt; selWbQ102 <= ctrl.selWb;
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            regDstQ103 <= '0; opcodeQ103 <= tOpcode'(7'd0); regWrEnQ103 <= 1'b0;
            DMemWrEnQ103H <= 1'b0; DMemRdEnQ103H <= 1'b0; DMemByteEnQ103H <= '0;
            signExtQ103 <= 1'b0; selWbQ103 <= WB_ALU;
            regDstQ104 <= '0; regWrEnQ104 <= 1'b0; signExtQ104 <= 1'b0; selWbQ104 <= WB_ALU;
            RegDstQ105H <= '0; regWrEnQ105 <= 1'b0;
            SignExtQ105H <= 1'b0; SelWrBackQ105H <= WB_ALU;
        end else if (DMemReady) begin
            // Q102 -> Q103, memory stage
            regDstQ103 <= regDstQ102; opcodeQ103 <= opcodeQ102; regWrEnQ103 <= regWrEnQ102;
            DMemWrEnQ103H <= dMemWrEnQ102; DMemRdEnQ103H <= dMemRdEnQ102;
            DMemByteEnQ103H <= dMemByteEnQ102;
            signExtQ103 <= signExtQ102; selWbQ103 <= selWbQ102;
            // Q103 -> Q104 -> Q105, write-back fields only
            regDstQ104 <= regDstQ103; regWrEnQ104 <= regWrEnQ103;
            signExtQ104 <= signExtQ103; selWbQ104 <= selWbQ103;
            RegDstQ105H <= regDstQ104; regWrEnQ105 <= regWrEnQ104;
            SignExtQ105H <= signExtQ104; SelWrBackQ105H <= selWbQ104;
        end
    end

    assign RegWrEnQ105H = ValidInstQ105H && regWrEnQ105;  // Bubbles never write

    // Hazard feedback
    assign fb.regDstQ102      = regDstQ102;
    assign fb.regDstQ103      = regDstQ103;
    assign fb.isLoadValidQ102 = validQ102 && (opcodeQ102 == LOAD);
    assign fb.isLoadValidQ103 = validQ103 && (opcodeQ103 == LOAD);
    assign fb.selNextPcJQ102  = selNextPcJQ102;
    assign fb.selNextPcBQ102  = selNextPcBQ102;

    validKnown: assert property (@(posedge Clock) disable iff (!arstN)
        !$isunknown(ValidInstQ105H));

endmodule

// ==== rrvDecode.sv ====
// Q101 decoder that turns the fetched instruction into the control word and immediate
`timescale 1ns/1ps
`include "rrv_defines.svh"

module rrvDecode
    import rrvPkg::*;
(
    input  tWord      preInstruction,
    input  logic      insertNop,
    output tWord      immediate,
    ctrlWordIf.dec    ctrl
);

    tWord    inst;
    tOpcode  opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    tImmType immType;
    logic    memAccess;

    // Bubble replaces the fetched word on hazard or flush
    assign inst   = insertNop ? `RRV_NOP : preInstruction;
    assign opcode = tOpcode'(inst[6:0]);
    assign funct3 = inst[`RRV_F3_LSB +: 3];
    assign funct7 = inst[`RRV_F7_LSB +: 7];
    assign memAccess = (opcode == LOAD) || (opcode == STORE);

    // ------------------------------------------------------------------------
    // Control bits
    // ------------------------------------------------------------------------
    assign ctrl.preValid   = !insertNop;
    assign ctrl.opcode     = opcode;
    assign ctrl.regDst     = inst[`RRV_RD_LSB +: `RRV_REG_W];
    assign ctrl.regSrc1    = inst[`RRV_RS1_LSB +: `RRV_REG_W];
    assign ctrl.regSrc2    = inst[`RRV_RS2_LSB +: `RRV_REG_W];
    assign ctrl.branchOp   = tBranchType'(funct3);
    assign ctrl.selNextPcJ = (opcode == JAL) || (opcode == JALR);
    assign ctrl.selNextPcB = (opcode == BRANCH);
    assign ctrl.selAluPc   = (opcode == JAL) || (opcode == BRANCH) || (opcode == AUIPC);
    assign ctrl.selAluImm  = (opcode != R_OP);  // Reg-reg ops only use rs2
    assign ctrl.lui        = (opcode == LUI);
    assign ctrl.dMemWrEn   = (opcode == STORE);
    assign ctrl.dMemRdEn   = (opcode == LOAD);
    assign ctrl.signExt    = (opcode == LOAD) && !funct3[2];  // LB/LH/LW, not LBU/LHU
    assign ctrl.regWrEn    = (opcode == LUI)  || (opcode == AUIPC) || (opcode == JAL)
                          || (opcode == JALR) || (opcode == LOAD)  || (opcode == I_OP)
                          || (opcode == R_OP) || (opcode == FENCE);
    assign ctrl.selWb      = ctrl.selNextPcJ   ? WB_PC4  :
                             (opcode == LOAD)  ? WB_DMEM : WB_ALU;

    always_comb begin
        ctrl.dMemByteEn = '0;
        if (memAccess) begin
            case (funct3[1:0])
                2'b00:   ctrl.dMemByteEn = 4'b0001;  // Byte
                2'b01:   ctrl.dMemByteEn = 4'b0011;  // Half
                2'b10:   ctrl.dMemByteEn = 4'b1111;  // Word
                default: ctrl.dMemByteEn = '0;
            endcase
        end
    end

    // ALU op from funct3/funct7 with add for address and link math
    always_comb begin
        casez ({funct3, funct7, opcode})
            {3'b000, 7'b0000000, R_OP}: ctrl.aluOp = ADD;
            {3'b000, 7'b0100000, R_OP}: ctrl.aluOp = SUB;
            {3'b001, 7'b0000000, R_OP}: ctrl.aluOp = SLL;
            {3'b010, 7'b0000000, R_OP}: ctrl.aluOp = SLT;
            {3'b011, 7'b0000000, R_OP}: ctrl.aluOp = SLTU;
            {3'b100, 7'b0000000, R_OP}: ctrl.aluOp = XOR;
            {3'b101, 7'b0000000, R_OP}: ctrl.aluOp = SRL;
            {3'b101, 7'b0100000, R_OP}: ctrl.aluOp = SRA;
            {3'b110, 7'b0000000, R_OP}: ctrl.aluOp = OR;
            {3'b111, 7'b0000000, R_OP}: ctrl.aluOp = AND;
            {3'b010, 7'b???????, I_OP}: ctrl.aluOp = SLT;
            {3'b011, 7'b???????, I_OP}: ctrl.aluOp = SLTU;
            {3'b100, 7'b???????, I_OP}: ctrl.aluOp = XOR;
            {3'b110, 7'b???????, I_OP}: ctrl.aluOp = OR;
            {3'b111, 7'b???????, I_OP}: ctrl.aluOp = AND;
            {3'b001, 7'b0000000, I_OP}: ctrl.aluOp = SLL;   // Shift amount in rs2 slot
            {3'b101, 7'b0000000, I_OP}: ctrl.aluOp = SRL;
            {3'b101, 7'b0100000, I_OP}: ctrl.aluOp = SRA;
            default:                    ctrl.aluOp = ADD;   // ADDI, loads, stores, jumps
        endcase
    end

    // ------------------------------------------------------------------------
    // Immediate generation
    // ------------------------------------------------------------------------
    always_comb begin
        case (opcode)
            LUI, AUIPC: immType = U_TYPE;
            JAL:        immType = J_TYPE;
            BRANCH:     immType = B_TYPE;
            STORE:      immType = S_TYPE;
            default:    immType = I_TYPE;  // JALR, loads, I_OP
        endcase
    end

    always_comb begin
        case (immType)
            U_TYPE:  immediate = {inst[31:12], 12'b0};
            S_TYPE:  immediate = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            B_TYPE:  immediate = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            J_TYPE:  immediate = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: immediate = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

endmodule

// ==== rrvHazard.sv ====
// Load-use hazard detection, Q102 redirect, flush tracking and fetch Ready levels
`timescale 1ns/1ps
`include "rrv_defines.svh"

module rrvHazard
    import rrvPkg::*;
(
    input  logic      Clock,
    input  logic      arstN,
    input  logic      DMemReady,
    input  tWord      preInstruction,
    input  logic      branchCondMet,
    hazardFbIf.haz    fb,
    output logic      insertNop,
    output logic      readyQ101,
    output logic      readyQ100,
    output logic      selNextPcAluOut
);

    tOpcode preOpcode;
    tRegIdx preRs1, preRs2;
    logic   useRs2;
    logic   loadHzQ102, loadHzQ103, loadHazard;
    logic   flushQ102, flushQ103;

    // Fields straight from the fetched word, ahead of NOP insertion
    assign preOpcode = tOpcode'(preInstruction[6:0]);
    assign preRs1    = preInstruction[`RRV_RS1_LSB +: `RRV_REG_W];
    assign preRs2    = preInstruction[`RRV_RS2_LSB +: `RRV_REG_W];
    assign useRs2    = (preOpcode == R_OP) || (preOpcode == STORE) || (preOpcode == BRANCH);

    // ------------------------------------------------------------------------
    // Load-use check with x0 included
    // ------------------------------------------------------------------------
    assign loadHzQ102 = fb.isLoadValidQ102 &&
                        ((fb.regDstQ102 == preRs1) || (useRs2 && fb.regDstQ102 == preRs2));
    assign loadHzQ103 = fb.isLoadValidQ103 &&
                        ((fb.regDstQ103 == preRs1) || (useRs2 && fb.regDstQ103 == preRs2));
    assign loadHazard = loadHzQ102 || loadHzQ103;

    // Jump, or branch taken, resolved in Q102
    assign flushQ102       = fb.selNextPcJQ102 || (fb.selNextPcBQ102 && branchCondMet);
    assign selNextPcAluOut = flushQ102;

    // Second wrong-path slot
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            flushQ103 <= 1'b0;
        end else if (DMemReady) begin
            flushQ103 <= flushQ102;
        end
    end

    assign insertNop = flushQ102 || flushQ103 || loadHazard;

    // Flush overrides the stall since the bubble goes in anyway
    assign readyQ101 = (DMemReady && !loadHazard) || flushQ102 || flushQ103;
    assign readyQ100 = DMemReady && readyQ101;

    // Squashed slot behind a redirect reaches Q102 as a NOP and never redirects
    redirectSquashesNext: assert property (@(posedge Clock) disable iff (!arstN)
        (selNextPcAluOut && DMemReady) |=> !selNextPcAluOut);

endmodule

// ==== rrvIfs.sv ====
// Control word and hazard feedback bundles between decode, pipe and hazard blocks
`timescale 1ns/1ps

// Q101 control word, decoder to pipe registers
interface ctrlWordIf
    import rrvPkg::*;
();
    tRegIdx     regDst, regSrc1, regSrc2;
    tOpcode     opcode;
    tAluOp      aluOp;
    tBranchType branchOp;
    logic       selAluPc, selAluImm, lui;
    logic       regWrEn, dMemWrEn, dMemRdEn;
    tByteEn     dMemByteEn;
    logic       signExt;
    tSelWb      selWb;
    logic       selNextPcJ, selNextPcB;
    logic       preValid;             // Low on an inserted NOP

    modport dec (output regDst, regSrc1, regSrc2, opcode, aluOp, branchOp, selAluPc,
                 selAluImm, lui, regWrEn, dMemWrEn, dMemRdEn, dMemByteEn, signExt,
                 selWb, selNextPcJ, selNextPcB, preValid);
    modport pipe (input regDst, opcode, aluOp, branchOp, selAluPc, selAluImm, lui,
                  regWrEn, dMemWrEn, dMemRdEn, dMemByteEn, signExt, selWb,
                  selNextPcJ, selNextPcB, preValid);
endinterface

// Q102/Q103 state back to hazard and redirect logic
interface hazardFbIf
    import rrvPkg::*;
();
    tRegIdx regDstQ102, regDstQ103;
    logic   isLoadValidQ102, isLoadValidQ103;
    logic   selNextPcJQ102, selNextPcBQ102;

    modport pipe (output regDstQ102, isLoadValidQ102, regDstQ103, isLoadValidQ103,
                  selNextPcJQ102, selNextPcBQ102);
    modport haz (input regDstQ102, isLoadValidQ102, regDstQ103, isLoadValidQ103,
                 selNextPcJQ102, selNextPcBQ102);
endinterface

// ==== rrvPkg.sv ====
// Opcode, ALU, immediate, branch and write-back types for the RV32I control unit
package rrvPkg;

`include "rrv_defines.svh"

    typedef logic [`RRV_XLEN-1:0]  tWord;    // Instruction, PC or immediate
    typedef logic [`RRV_REG_W-1:0] tRegIdx;  // Register file index
    typedef logic [3:0]            tByteEn;  // One bit per byte lane

    // ------------------------------------------------------------------------
    // Major opcodes, bits 6:0
    // ------------------------------------------------------------------------
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        I_OP   = 7'b0010011,
        R_OP   = 7'b0110011,
        FENCE  = 7'b0001111,
        SYSCAL = 7'b1110011   // Decoded as NOP
    } tOpcode;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } tAluOp;

    typedef enum logic [2:0] {
        I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE
    } tImmType;

    // Same coding as funct3 of a branch
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } tBranchType;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_DMEM,
        WB_PC4   // Link address for JAL/JALR
    } tSelWb;

endpackage

// ==== rrv_defines.svh ====
// RV32I control unit widths, NOP encoding, instruction field offsets and pipe depth
`ifndef RRV_DEFINES_SVH
`define RRV_DEFINES_SVH

// Datapath and register file
`define RRV_XLEN        32
`define RRV_REG_W       5

// ADDI x0, x0, 0
`define RRV_NOP         32'h0000_0013

// Instruction field offsets
`define RRV_RD_LSB      7
`define RRV_F3_LSB      12
`define RRV_RS1_LSB     15
`define RRV_RS2_LSB     20
`define RRV_F7_LSB      25

// Last stage index, Q101 to Q105
`define RRV_PIPE_DEPTH  5

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the RV32I control unit testbench with Verilator

cd "$(dirname "$0")" || { echo "Cannot enter project directory"; exit 1; }

LOG=sim.log

verilator --binary -j 0 --assert --timing --top-module tbRrvCtrl -f compile.f -o simRrvCtrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simRrvCtrl > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== tbRrvCtrl.sv ====
// Self-checking testbench for the RV32I control unit, LFSR stimulus against a reference model
`timescale 1ns/1ps
`include "rrv_defines.svh"

module tbRrvCtrl
    import rrvPkg::*;
();

    localparam int NumCycles   = 1500;
    localparam int ResetCycles = 4;
    localparam int MaxCycles   = 2000;   // 1500 stimulus + reset + drain margin

    // One pipe slot of the reference model
    typedef struct packed {
        logic       valid;
        logic [6:0] opcode;
        logic [4:0] rd;
        logic [3:0] aluOp;
        logic [2:0] branchOp;
        logic       lui, selAluPc, selAluImm, regWrEn, dMemWrEn, dMemRdEn, signExt;
        logic [3:0] byteEn;
        logic [1:0] selWb;
        logic       isJump, isBranch;
    } tSlot;

    logic       Clock, arstN, DMemReady, BranchCondMetQ102H;
    tWord       PreInstructionQ101H, PcQ101H, ImmediateQ101H;
    logic       ReadyQ100H, ReadyQ101H, SelNextPcAluOutQ102H;
    tRegIdx     RegSrc1Q101H, RegSrc2Q101H, RegDstQ105H;
    tAluOp      AluOpQ102H;
    tBranchType BranchOpQ102H;
    logic       LuiQ102H, SelAluPcQ102H, SelAluImmQ102H;
    logic       DMemWrEnQ103H, DMemRdEnQ103H;
    tByteEn     DMemByteEnQ103H;
    logic       RegWrEnQ105H, SignExtQ105H, ValidInstQ105H;
    tSelWb      SelWrBackQ105H;

    tSlot        pipe [4];          // Q102, Q103, Q104, Q105
    logic        flushQ103;         // Model copy of the second squash slot
    logic [31:0] lfsr;
    int          cycleCount  = 0;
    int          hazardCount = 0;
    int          flushCount  = 0;
    int          freezeCount = 0;
    int          validCount  = 0;

    rrvCtrl uut (.*);

    initial Clock = 1'b0;
    always #50 Clock = ~Clock;     // 100 ns period

    // Hang guard
    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MaxCycles) begin
            $display("Timeout: run did not finish within %0d cycles", MaxCycles);
            $display("Result: FAILED");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic        fb;
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] randomInstruction();
        logic [31:0] w;
        logic [3:0]  cls;
        logic [1:0]  f7Sel;
        w     = randBits(32);
        cls   = 4'(randBits(4));
        f7Sel = 2'(randBits(2));
        case (cls)
            4'd0:             w[6:0] = LUI;
            4'd1:             w[6:0] = AUIPC;
            4'd2:             w[6:0] = JAL;
            4'd3:             w[6:0] = JALR;
            4'd4:             w[6:0] = BRANCH;
            4'd5, 4'd6, 4'd7: w[6:0] = LOAD;     // Loads weighted up for hazards
            4'd8:             w[6:0] = STORE;
            4'd9, 4'd10:      w[6:0] = I_OP;
            4'd11, 4'd12:     w[6:0] = R_OP;
            4'd13:            w[6:0] = FENCE;
            default:          w[6:0] = SYSCAL;
        endcase
        // Registers x0..x7 only, so load-use matches are frequent
        w[11:10] = 2'b00;
        w[19:18] = 2'b00;
        w[24:23] = 2'b00;
        if (f7Sel == 2'd0) w[31:25] = 7'h00;
        if (f7Sel == 2'd1) w[31:25] = 7'h20;  // SUB/SRA
        return w;
    endfunction

    // ------------------------------------------------------------------------
    // Reference decode
    // ------------------------------------------------------------------------
    function automatic tSlot decodeModel(input logic [31:0] w);
        tSlot       s;
        logic [6:0] op;
        logic [2:0] f3;
        logic       rType, shift, alt, fieldOk;
        op      = w[6:0];
        f3      = w[14:12];
        rType   = (op == R_OP);
        shift   = (f3 == 3'b001) || (f3 == 3'b101);
        alt     = (w[31:25] == 7'h20);
        fieldOk = (op == I_OP && !shift) || (w[31:25] == 7'h00) ||
                  (alt && (f3 == 3'b101 || (rType && f3 == 3'b000)));
        s            = '0;
        s.opcode     = op;
        s.rd         = w[11:7];
        s.branchOp   = f3;
        s.isJump     = (op == JAL) || (op == JALR);
        s.isBranch   = (op == BRANCH);
        s.lui        = (op == LUI);
        s.selAluPc   = (op == JAL) || (op == BRANCH) || (op == AUIPC);
        s.selAluImm  = !rType;
        s.dMemWrEn   = (op == STORE);
        s.dMemRdEn   = (op == LOAD);
        s.signExt    = (op == LOAD) && !f3[2];                  // LBU/LHU zero-extend
        s.selWb      = s.isJump ? WB_PC4 : ((op == LOAD) ? WB_DMEM : WB_ALU);
        case (op)
            LUI, AUIPC, JAL, JALR, LOAD, I_OP, R_OP, FENCE: s.regWrEn = 1'b1;
            default:                                        s.regWrEn = 1'b0;  // SYSTEM is a NOP
        endcase
        if (op == LOAD || op == STORE) begin
            case (f3[1:0])
                2'b00:   s.byteEn = 4'b0001;
                2'b01:   s.byteEn = 4'b0011;
                2'b10:   s.byteEn = 4'b1111;
                default: s.byteEn = 4'b0000;
            endcase
        end
        s.aluOp = ADD;                                           // Address and link math
        if ((rType || op == I_OP) && fieldOk) begin
            case (f3)
                3'b000:  s.aluOp = (rType && alt) ? SUB : ADD;
                3'b001:  s.aluOp = SLL;
                3'b010:  s.aluOp = SLT;
                3'b011:  s.aluOp = SLTU;
                3'b100:  s.aluOp = XOR;
                3'b101:  s.aluOp = alt ? SRA : SRL;
                3'b110:  s.aluOp = OR;
                default: s.aluOp = AND;
            endcase
        end
        return s;
    endfunction

    function automatic logic [31:0] immediateModel(input logic [31:0] w);
        case (w[6:0])
            LUI, AUIPC: return {w[31:12], 12'h000};
            JAL:        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            BRANCH:     return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            STORE:      return {{20{w[31]}}, w[31:25], w[11:7]};
            default:    return {{20{w[31]}}, w[31:20]};
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        assert (actVal === expVal) else begin
            $display("Error %s: expected %0h actual %0h at %0t", name, expVal, actVal, $time);
            $display("Result: FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // ------------------------------------------------------------------------
    // One cycle of the model, compared with the DUT at the falling edge
    // ------------------------------------------------------------------------
    task automatic checkAndAdvance(output logic accept);
        tSlot        dec;
        logic [4:0]  rs1, rs2;
        logic        useRs2, loadQ102, loadQ103, hazard, flushNow, insNop, ready101;
        logic [31:0] word;
        int          i;
        rs1      = PreInstructionQ101H[19:15];
        rs2      = PreInstructionQ101H[24:20];
        useRs2   = (PreInstructionQ101H[6:0] == R_OP) || (PreInstructionQ101H[6:0] == STORE) ||
                   (PreInstructionQ101H[6:0] == BRANCH);
        loadQ102 = pipe[0].valid && DMemReady && (pipe[0].opcode == LOAD);  // Frozen pipe hides it
        loadQ103 = pipe[1].valid && DMemReady && (pipe[1].opcode == LOAD);
        hazard   = (loadQ102 && (pipe[0].rd == rs1 || (useRs2 && pipe[0].rd == rs2))) ||
                   (loadQ103 && (pipe[1].rd == rs1 || (useRs2 && pipe[1].rd == rs2)));
        flushNow = pipe[0].isJump || (pipe[0].isBranch && BranchCondMetQ102H);
        insNop   = hazard || flushNow || flushQ103;
        ready101 = (DMemReady && !hazard) || flushNow || flushQ103;
        word     = insNop ? `RRV_NOP : PreInstructionQ101H;
        dec      = decodeModel(word);

        checkValue("ReadyQ101H", 32'(ready101), 32'(ReadyQ101H));
        checkValue("ReadyQ100H", 32'(DMemReady && ready101), 32'(ReadyQ100H));
        checkValue("SelNextPcAluOutQ102H", 32'(flushNow), 32'(SelNextPcAluOutQ102H));
        checkValue("RegSrc1Q101H", 32'(word[19:15]), 32'(RegSrc1Q101H));
        checkValue("RegSrc2Q101H", 32'(word[24:20]), 32'(RegSrc2Q101H));
        checkValue("ImmediateQ101H", immediateModel(word), ImmediateQ101H);
        checkValue("AluOpQ102H", 32'(pipe[0].aluOp), 32'(AluOpQ102H));
        checkValue("BranchOpQ102H", 32'(pipe[0].branchOp), 32'(BranchOpQ102H));
        checkValue("LuiQ102H", 32'(pipe[0].lui), 32'(LuiQ102H));
        checkValue("SelAluPcQ102H", 32'(pipe[0].selAluPc), 32'(SelAluPcQ102H));
        checkValue("SelAluImmQ102H", 32'(pipe[0].selAluImm), 32'(SelAluImmQ102H));
        checkValue("DMemWrEnQ103H", 32'(pipe[1].dMemWrEn), 32'(DMemWrEnQ103H));
        checkValue("DMemRdEnQ103H", 32'(pipe[1].dMemRdEn), 32'(DMemRdEnQ103H));
        checkValue("DMemByteEnQ103H", 32'(pipe[1].byteEn), 32'(DMemByteEnQ103H));
        checkValue("RegDstQ105H", 32'(pipe[3].rd), 32'(RegDstQ105H));
        checkValue("SignExtQ105H", 32'(pipe[3].signExt), 32'(SignExtQ105H));
        checkValue("SelWrBackQ105H", 32'(pipe[3].selWb), 32'(SelWrBackQ105H));
        checkValue("ValidInstQ105H", 32'(pipe[3].valid && DMemReady), 32'(ValidInstQ105H));
        checkValue("RegWrEnQ105H", 32'(pipe[3].valid && DMemReady && pipe[3].regWrEn),
                   32'(RegWrEnQ105H));

        if (hazard) hazardCount++;
        if (flushNow) flushCount++;
        if (!DMemReady) freezeCount++;
        if (pipe[3].valid && DMemReady) validCount++;

        // Queue moves only with the freeze released
        if (DMemReady) begin
            dec.valid = !insNop && ready101;
            for (i = 3; i > 0; i--) pipe[i] = pipe[i-1];
            pipe[0]   = dec;
            flushQ103 = flushNow;
        end
        accept = DMemReady && ready101;
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [23:0] held, heldPrev;
        logic        frozePrev, accept;
        int          n;
        lfsr                = 32'hbfff3ae5;
        arstN               <= 1'b0;
        DMemReady           <= 1'b1;
        BranchCondMetQ102H  <= 1'b0;
        PreInstructionQ101H <= `RRV_NOP;
        PcQ101H             <= '0;
        foreach (pipe[i]) pipe[i] = '0;
        flushQ103 = 1'b0;
        frozePrev = 1'b0;
        heldPrev  = '0;

        repeat (ResetCycles) begin
            @(negedge Clock);
            checkValue("ResetValidInstQ105H", 32'h0, 32'(ValidInstQ105H));
            checkValue("ResetRegWrEnQ105H", 32'h0, 32'(RegWrEnQ105H));
        end
        @(posedge Clock);
        arstN <= 1'b1;

        for (n = 0; n < NumCycles; n++) begin
            @(negedge Clock);
            held = {AluOpQ102H, BranchOpQ102H, LuiQ102H, SelAluPcQ102H, SelAluImmQ102H,
                    DMemWrEnQ103H, DMemRdEnQ103H, DMemByteEnQ103H, RegDstQ105H,
                    SignExtQ105H, SelWrBackQ105H};
            if (frozePrev) checkValue("FreezeHold", 32'(heldPrev), 32'(held));
            heldPrev  = held;
            frozePrev = !DMemReady;
            checkAndAdvance(accept);
            @(posedge Clock);
            if (accept) begin                      // Fetch holds while ReadyQ100H is low
                PreInstructionQ101H <= randomInstruction();
                PcQ101H             <= PcQ101H + 32'd4;
            end
            DMemReady          <= (randBits(3) != 32'd0);   // Low about 1 in 8
            BranchCondMetQ102H <= (randBits(1) != 32'd0);
        end

        if (hazardCount > 0 && flushCount > 0 && freezeCount > 0 && validCount > 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Stimulus missed a hazard, flush, freeze or valid write-back case");
            $display("Result: FAILED");
            $fatal(1, "Scenario coverage incomplete");
        end
    end

endmodule
